//--- verilog.f
logic/pixel_pkg.sv
logic/frame_buffer_ram.sv
logic/blend_port.sv
logic/flush_sequencer.sv
logic/sdram_writer.sv
logic/output_controller.sv
sim/tb_output_controller.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the output controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f verilog.f --top-module tb_output_controller -Mdir obj_dir \
	&& ./obj_dir/Vtb_output_controller > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sim/tb_output_controller.sv
// Output controller testbench
`timescale 1ns/1ns
`default_nettype none

module tb_output_controller import pixel_pkg::*;
();

	localparam int wait_limit = 2000;

	logic clk = 1'b0;
	logic n_rst;
	logic write;
	logic read;
	logic frame_ready;
	pixel_t write_pixel;
	logic [pix_addr_w-1:0] pixel_number;
	pixel_t read_pixel;
	logic read_valid;
	sd_write_t sd_cmd;
	logic waitrequest = 1'b0;
	logic frame_done;

	// Behavioral SDRAM
	logic stall_en;
	logic hold_pending = 1'b0;
	sd_write_t last_cmd;
	sd_write_t sd_log[$];
	sd_write_t held_cmd[$];
	sd_write_t next_cmd[$];

	// Pixels the blender wrote into the current frame
	pixel_t frame_ref[$];
	int errors;
	int checks;
	logic timed_out;
	int seed_ret;

	output_controller u_dut
	(
		.clk(clk),
		.n_rst(n_rst),
		.write(write),
		.read(read),
		.frame_ready(frame_ready),
		.write_pixel(write_pixel),
		.pixel_number(pixel_number),
		.read_pixel(read_pixel),
		.read_valid(read_valid),
		.sd_cmd(sd_cmd),
		.waitrequest(waitrequest),
		.frame_done(frame_done)
	);

	always #4 clk = ~clk;

	// Random back-pressure while stalls are enabled
	always @(posedge clk)
	begin
		#1;
		waitrequest = stall_en && ($urandom % 2 == 1);
	end

	// Accepted writes, and the command seen the cycle after each stall
	always @(negedge clk)
	begin
		if (n_rst && hold_pending)
		begin
			held_cmd.push_back(last_cmd);
			next_cmd.push_back(sd_cmd);
		end
		if (n_rst && sd_cmd.write && !waitrequest)
		begin
			sd_log.push_back(sd_cmd);
		end
		hold_pending = n_rst && sd_cmd.write && waitrequest;
		last_cmd = sd_cmd;
	end

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_cmd(input sd_write_t got, input sd_write_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t ns: %s is %b/%h/%h, expected %b/%h/%h", $time, what,
				got.write, got.address, got.data, exp.write, exp.address, exp.data);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	function automatic pixel_t random_pixel();
		pixel_t p;
		p.r = 8'($urandom);
		p.g = 8'($urandom);
		p.b = 8'($urandom);
		return p;
	endfunction

	// One pixel per cycle, stored at the blender write counter
	task automatic write_frame(input int n);
		pixel_t p;
		int i;
		frame_ref.delete();
		for (i = 0; i < n; i++)
		begin
			p = random_pixel();
			frame_ref.push_back(p);
			write = 1'b1;
			write_pixel = p;
			next_cycle();
		end
		write = 1'b0;
	endtask

	// Every pixel in order first, then random pixel numbers
	task automatic read_back(input int reads);
		int i;
		int k;
		check_flag(read_valid, 1'b0, "read_valid before read");
		for (i = 0; i < reads; i++)
		begin
			k = (i < frame_ref.size()) ? i : int'($urandom % frame_ref.size());
			read = 1'b1;
			pixel_number = pix_addr_w'(k);
			next_cycle();
			check_flag(read_valid, 1'b1, "read_valid one cycle after read");
			check_pixel(read_pixel, frame_ref[k], $sformatf("read_pixel %0d", k));
		end
		read = 1'b0;
		next_cycle();
		check_flag(read_valid, 1'b0, "read_valid after last read");
	endtask

	// Optional blender traffic keeps going until frame_done
	task automatic wait_frame_done(input logic poke);
		int cycles;
		logic seen;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < wait_limit)
		begin
			if (poke)
			begin
				write = 1'b1;
				write_pixel = random_pixel();
				read = 1'b1;
				pixel_number = pix_addr_w'($urandom % 64);
			end
			next_cycle();
			cycles++;
			if (poke)
			begin
				check_flag(read_valid, 1'b0, "read_valid during flush");
			end
			seen = frame_done;
		end
		write = 1'b0;
		read = 1'b0;
		if (!seen)
		begin
			$display("Timeout: no frame_done within %0d cycles of frame_ready", wait_limit);
			timed_out = 1'b1;
		end
		else
		begin
			next_cycle();
			check_flag(frame_done, 1'b0, "frame_done one cycle later");
			check_flag(sd_cmd.write, 1'b0, "SDRAM write after frame_done");
		end
	endtask

	task automatic flush_frame(input logic stall, input logic poke, input string what);
		int log_base;
		int hold_base;
		int i;
		sd_write_t exp;
		log_base = sd_log.size();
		hold_base = held_cmd.size();
		stall_en = stall;
		frame_ready = 1'b1;
		next_cycle();
		frame_ready = 1'b0;
		wait_frame_done(poke);
		stall_en = 1'b0;
		if (timed_out)
		begin
			return;
		end
		checks++;
		if (sd_log.size() - log_base != frame_ref.size())
		begin
			errors++;
			$display("ERR %0t ns: %s wrote %0d words, expected %0d", $time, what,
				sd_log.size() - log_base, frame_ref.size());
		end
		for (i = 0; i < frame_ref.size() && log_base + i < sd_log.size(); i++)
		begin
			exp.write = 1'b1;
			exp.address = sd_addr_w'(4 * i);
			exp.data = {8'h00, frame_ref[i]};
			check_cmd(sd_log[log_base + i], exp, $sformatf("%s write %0d", what, i));
		end
		// Address and data must not move while waitrequest is high
		for (i = hold_base; i < held_cmd.size(); i++)
		begin
			check_cmd(next_cmd[i], held_cmd[i], $sformatf("%s command under stall", what));
		end
		if (stall)
		begin
			check_flag(held_cmd.size() > hold_base, 1'b1, "stall seen during flush");
		end
	endtask

	task automatic test_reset_state();
		check_flag(sd_cmd.write, 1'b0, "SDRAM write after reset");
		check_flag(read_valid, 1'b0, "read_valid after reset");
		check_flag(frame_done, 1'b0, "frame_done after reset");
		frame_ref.delete();
		flush_frame(1'b0, 1'b0, "empty flush");
	endtask

	task automatic test_write_readback();
		if (timed_out)
		begin
			return;
		end
		write_frame(24);
		read_back(48);
	endtask

	task automatic test_flush_clean();
		if (timed_out)
		begin
			return;
		end
		flush_frame(1'b0, 1'b0, "clean flush");
	endtask

	task automatic test_flush_stalled();
		if (timed_out)
		begin
			return;
		end
		write_frame(20);
		flush_frame(1'b1, 1'b0, "stalled flush");
	endtask

	// Second frame has to start again at pixel zero
	task automatic test_ignore_during_flush();
		if (timed_out)
		begin
			return;
		end
		write_frame(16);
		flush_frame(1'b1, 1'b1, "flush with blender traffic");
		if (timed_out)
		begin
			return;
		end
		write_frame(10);
		read_back(20);
		flush_frame(1'b0, 1'b0, "second frame flush");
	endtask

	initial
	begin
		seed_ret = $urandom(33);
		n_rst = 1'b0;
		write = 1'b0;
		read = 1'b0;
		frame_ready = 1'b0;
		write_pixel = '0;
		pixel_number = '0;
		stall_en = 1'b0;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		repeat (4) next_cycle();
		n_rst = 1'b1;
		test_reset_state();
		test_write_readback();
		test_flush_clean();
		test_flush_stalled();
		test_ignore_during_flush();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
		if (errors == 0 && !timed_out)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/output_controller.sv
// Graphics output controller
`timescale 1ns/1ns
`default_nettype none

module output_controller import pixel_pkg::*;
(
	input wire clk,
	input wire n_rst,

	// Alpha blender interface
	input wire write,
	input wire read,
	input wire frame_ready,
	input wire pixel_t write_pixel,
	input wire [pix_addr_w-1:0] pixel_number,
	output pixel_t read_pixel,
	output logic read_valid,

	// SDRAM interface
	output sd_write_t sd_cmd,
	input wire waitrequest,

	output logic frame_done
);

	ctrl_state_t state;
	logic blend_active;
	logic we;
	logic [pix_addr_w-1:0] write_address;
	logic [pix_addr_w-1:0] pixel_count;
	pixel_t wr_pixel;
	buf_read_t bp_rd_req;
	buf_read_t fs_rd_req;
	buf_read_t rd_req;
	buf_data_t rd_data;
	logic space;
	logic empty;
	// Marks a buffer result that answers a blender read
	logic host_tag;

	assign blend_active = state == blend;

	blend_port u_blend_port
	(
		.clk(clk),
		.n_rst(n_rst),
		.active(blend_active),
		.write(write),
		.read(read),
		.write_pixel(write_pixel),
		.pixel_number(pixel_number),
		.clear(frame_done),
		.we(we),
		.write_address(write_address),
		.wr_pixel(wr_pixel),
		.rd_req(bp_rd_req),
		.pixel_count(pixel_count)
	);

	flush_sequencer u_flush_sequencer
	(
		.clk(clk),
		.n_rst(n_rst),
		.frame_ready(frame_ready),
		.pixel_count(pixel_count),
		.space(space),
		.empty(empty),
		.state(state),
		.rd_req(fs_rd_req),
		.frame_done(frame_done)
	);

	// Blender owns the read port in blend state, the flush otherwise
	assign rd_req = blend_active ? bp_rd_req : fs_rd_req;

	frame_buffer_ram u_frame_buffer_ram
	(
		.clk(clk),
		.we(we),
		.write_address(write_address),
		.write_pixel(wr_pixel),
		.rd_req(rd_req),
		.rd_data(rd_data)
	);

	sdram_writer u_sdram_writer
	(
		.clk(clk),
		.n_rst(n_rst),
		.issue(fs_rd_req.valid),
		.pix_in(rd_data),
		.waitrequest(waitrequest),
		.sd_cmd(sd_cmd),
		.space(space),
		.empty(empty)
	);

	always_ff @(posedge clk)
	begin
		if (n_rst == 1'b0)
		begin
			host_tag <= 1'b0;
		end
		else
		begin
			host_tag <= blend_active && rd_req.valid;
		end
	end

	assign read_pixel = rd_data.pix;
	assign read_valid = rd_data.valid && host_tag;

endmodule

`default_nettype wire

//--- logic/sdram_writer.sv
// SDRAM write queue
`timescale 1ns/1ns
`default_nettype none

module sdram_writer import pixel_pkg::*;
(
	input wire clk,
	input wire n_rst,

	// Flush read issued to the frame buffer this cycle
	input wire issue,
	input wire buf_data_t pix_in,

	input wire waitrequest,
	output sd_write_t sd_cmd,

	output logic space,
	output logic empty
);

	logic [qcnt_w-1:0] count;
	logic [qptr_w-1:0] wr_ptr;
	logic [qptr_w-1:0] rd_ptr;
	logic inflight;
	logic [pix_addr_w-1:0] wr_index;
	logic [qcnt_w:0] used;
	logic push;
	logic pop;

	// Queue storage
	pixel_t q_pix [queue_depth];
	logic [pix_addr_w-1:0] q_index [queue_depth];

	// Only data that answers a flush read is queued
	assign push = inflight && pix_in.valid;
	assign pop = (count != '0) && !waitrequest;

	// An entry leaving this cycle frees its slot for the next issue
	assign used = (qcnt_w+1)'(count) + (qcnt_w+1)'(inflight) - (qcnt_w+1)'(pop);
	assign space = used < (qcnt_w+1)'(queue_depth);

	// Nothing queued and nothing on its way from the buffer
	assign empty = (count == '0) && !inflight;

	always_ff @(posedge clk)
	begin
		if (n_rst == 1'b0)
		begin
			count <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			inflight <= 1'b0;
			wr_index <= '0;
		end
		else
		begin
			inflight <= issue;
			count <= count + qcnt_w'(push) - qcnt_w'(pop);
			if (push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Idle between frames, so the next flush starts at address zero
			if (empty && !issue)
			begin
				wr_index <= '0;
			end
			else if (push)
			begin
				wr_index <= wr_index + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			q_pix[wr_ptr] <= pix_in.pix;
			q_index[wr_ptr] <= wr_index;
		end
	end

	// Head entry stays put until SDRAM drops waitrequest
	always_comb
	begin
		sd_cmd.write = count != '0;
		sd_cmd.address = sd_addr_w'(q_index[rd_ptr]) << addr_shift;
		sd_cmd.data = {{pad_w{1'b0}}, q_pix[rd_ptr]};
	end

endmodule

`default_nettype wire

//--- logic/flush_sequencer.sv
// Controller FSM and flush address issue
`timescale 1ns/1ns
`default_nettype none

module flush_sequencer import pixel_pkg::*;
(
	input wire clk,
	input wire n_rst,

	// Blender says the frame is complete
	input wire frame_ready,
	input wire [pix_addr_w-1:0] pixel_count,

	// Credit and drain status from the SDRAM writer
	input wire space,
	input wire empty,

	output ctrl_state_t state,
	output buf_read_t rd_req,
	output logic frame_done
);

	ctrl_state_t next_state;
	logic [pix_addr_w-1:0] index;
	logic all_issued;

	assign all_issued = index >= pixel_count;

	// One request per cycle while a credit is held
	always_comb
	begin
		rd_req.valid = (state == flush) && !all_issued && space;
		rd_req.address = index;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			blend:
			begin
				if (frame_ready)
				begin
					next_state = flush;
				end
			end
			flush:
			begin
				// Every pixel read and the last write taken by SDRAM
				if (all_issued && empty)
				begin
					next_state = done;
				end
			end
			done:
			begin
				next_state = blend;
			end
			default:
			begin
				next_state = blend;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (n_rst == 1'b0)
		begin
			state <= blend;
		end
		else
		begin
			state <= next_state;
		end
	end

	// Flush index restarts for every frame
	always_ff @(posedge clk)
	begin
		if (n_rst == 1'b0)
		begin
			index <= '0;
		end
		else if (state != flush)
		begin
			index <= '0;
		end
		else if (rd_req.valid)
		begin
			index <= index + 1'b1;
		end
	end

	// Single cycle pulse, also clears the blender write counter
	assign frame_done = state == done;

endmodule

`default_nettype wire

//--- logic/blend_port.sv
// Blender side of the frame buffer
`timescale 1ns/1ns
`default_nettype none

module blend_port import pixel_pkg::*;
(
	input wire clk,
	input wire n_rst,

	// High while the controller is in blend state
	input wire active,

	// From the alpha blender
	input wire write,
	input wire read,
	input wire pixel_t write_pixel,
	input wire [pix_addr_w-1:0] pixel_number,

	// End of flush, restart the frame at pixel zero
	input wire clear,

	// Toward the frame buffer
	output logic we,
	output logic [pix_addr_w-1:0] write_address,
	output pixel_t wr_pixel,
	output buf_read_t rd_req,

	// Number of pixels written this frame
	output logic [pix_addr_w-1:0] pixel_count
);

	logic [pix_addr_w-1:0] count;
	logic full;

	// Counter stops at the frame size
	assign full = count >= pix_addr_w'(frame_pixels);

	// Accept a write only in blend state and while there is room
	assign we = active && write && !full;
	assign write_address = count;
	assign wr_pixel = write_pixel;

	always_ff @(posedge clk)
	begin
		if (n_rst == 1'b0)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;
		end
		else if (we)
		begin
			count <= count + 1'b1;
		end
	end

	// Blender read, data comes back one cycle later
	always_comb
	begin
		rd_req.valid = active && read;
		rd_req.address = pixel_number;
	end

	assign pixel_count = count;

endmodule

`default_nettype wire

//--- logic/frame_buffer_ram.sv
// Frame buffer pixel memory
`timescale 1ns/1ns
`default_nettype none

module frame_buffer_ram import pixel_pkg::*;
(
	input wire clk,

	// Write port from the blender
	input wire we,
	input wire [pix_addr_w-1:0] write_address,
	input wire pixel_t write_pixel,

	// Shared read port
	input wire buf_read_t rd_req,
	output buf_data_t rd_data
);

	// One pixel per word, inferred as block RAM
	pixel_t mem [frame_pixels];

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[write_address] <= write_pixel;
		end
	end

	// Registered read, the valid bit travels with the data
	always_ff @(posedge clk)
	begin
		rd_data.pix <= mem[rd_req.address];
		rd_data.valid <= rd_req.valid;
	end

endmodule

`default_nettype wire

//--- logic/pixel_pkg.sv
// Output controller shared types
`default_nettype none

package pixel_pkg;

	// Frame geometry, 320 by 240
	localparam int frame_pixels = 76800;
	localparam int pix_addr_w = 17;

	// Pixel layout
	localparam int chan_w = 8;
	localparam int pixel_w = 3 * chan_w;

	// SDRAM port
	localparam int sd_addr_w = 26;
	localparam int sd_data_w = 32;
	// Top byte of each data word is zero
	localparam int pad_w = sd_data_w - pixel_w;
	// Byte address is pixel index times four
	localparam int addr_shift = 2;

	// SDRAM write queue
	localparam int queue_depth = 2;
	localparam int qcnt_w = $clog2(queue_depth + 1);
	localparam int qptr_w = $clog2(queue_depth);

	// Who owns the frame buffer
	typedef enum logic [1:0]
	{
		blend = 2'd0,
		flush = 2'd1,
		done = 2'd2
	} ctrl_state_t;

	typedef struct packed
	{
		logic [chan_w-1:0] r;
		logic [chan_w-1:0] g;
		logic [chan_w-1:0] b;
	} pixel_t;

	// Read request into the frame buffer
	typedef struct packed
	{
		logic valid;
		logic [pix_addr_w-1:0] address;
	} buf_read_t;

	// Frame buffer read result
	typedef struct packed
	{
		logic valid;
		pixel_t pix;
	} buf_data_t;

	typedef struct packed
	{
		logic write;
		logic [sd_addr_w-1:0] address;
		logic [sd_data_w-1:0] data;
	} sd_write_t;

endpackage

`default_nettype wire
